/* source/csr_addr_pkg.sv */
//////////////////////////////
// CSR address map
// Addresses, selectors, write masks and constant values
//////////////////////////////
`default_nettype none

package csr_addr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    typedef enum logic [CSR_ADDR_W-1:0] {
        ADDR_MVENDORID  = 12'hF11,
        ADDR_MARCHID    = 12'hF12,
        ADDR_MIMPID     = 12'hF13,
        ADDR_MHARTID    = 12'hF14,
        ADDR_MCONFIGPTR = 12'hF15,
        ADDR_MSTATUS    = 12'h300,
        ADDR_MISA       = 12'h301,
        ADDR_MIE        = 12'h304,
        ADDR_MTVEC      = 12'h305,
        ADDR_MSCRATCH   = 12'h340,
        ADDR_MEPC       = 12'h341,
        ADDR_MCAUSE     = 12'h342,
        ADDR_MTVAL      = 12'h343,
        ADDR_MIP        = 12'h344,
        ADDR_MCYCLE     = 12'hB00,
        ADDR_MINSTRET   = 12'hB02,
        ADDR_MCYCLEH    = 12'hB80,
        ADDR_MINSTRETH  = 12'hB82,
        ADDR_CYCLE      = 12'hC00,
        ADDR_INSTRET    = 12'hC02,
        ADDR_CYCLEH     = 12'hC80,
        ADDR_INSTRETH   = 12'hC82
    } csr_addr_e;

    // One selector per implemented register
    typedef enum logic [4:0] {
        SEL_NONE, SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID,
        SEL_MCONFIGPTR, SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC,
        SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
        SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
        SEL_CYCLE, SEL_CYCLEH, SEL_INSTRET, SEL_INSTRETH
    } csr_sel_e;

    localparam logic [XLEN-1:0] MASK_MSTATUS = 32'h007E_19AA;
    localparam logic [XLEN-1:0] MASK_MIE     = 32'h0000_0888;   // MSIE, MTIE, MEIE
    localparam logic [XLEN-1:0] MASK_ALIGNED = 32'hFFFF_FFFC;   // Word aligned targets
    localparam logic [XLEN-1:0] MASK_FULL    = 32'hFFFF_FFFF;

    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4000_0100;   // RV32I

endpackage

`default_nettype wire

/* source/csr_trap_pkg.sv */
//////////////////////////////
// Trap definitions
// CSR operations, privilege, cause codes, mstatus fields
//////////////////////////////
`default_nettype none

package csr_trap_pkg;

    // Matches funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        INSTRUCTION_MISALIGNED = 5'd0,
        ILLEGAL_INSTRUCTION    = 5'd2,
        BREAKPOINT             = 5'd3,
        LOAD_ACCESS_FAULT      = 5'd5,
        STORE_ACCESS_FAULT     = 5'd7,
        ECALL_FROM_MMODE       = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;    // MPP is two bits wide

endpackage

`default_nettype wire

/* source/csr_port_if.sv */
//////////////////////////////
// Decoded CSR access port
//////////////////////////////
`default_nettype none

interface csr_port_if
    import csr_addr_pkg::*;
();

    csr_sel_e        sel;
    logic            wr_en;
    logic [XLEN-1:0] wr_data;
    logic [XLEN-1:0] rd_data;      // Zero unless the register lives behind this port

    modport ctrl (output sel, output wr_en, output wr_data, input rd_data);
    modport regs (input sel, input wr_en, input wr_data, output rd_data);

endinterface

`default_nettype wire

/* source/csr_access_ctrl.sv */
//////////////////////////////
// CSR access control
// Address decode, masking, write gating, read merge
//////////////////////////////
`default_nettype none

module csr_access_ctrl
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic                  read_enable_i,
    input  logic                  write_enable_i,
    input  logic                  killed_i,
    input  logic                  raise_exception_i,
    input  logic                  machine_return_i,
    input  logic                  interrupt_ack_i,
    input  csr_op_e               operation_i,
    input  logic [CSR_ADDR_W-1:0] address_i,
    input  logic [XLEN-1:0]       data_i,
    output logic [XLEN-1:0]       read_data_o,
    csr_port_if.ctrl              trap_port,
    csr_port_if.ctrl              cnt_port,
    csr_port_if.ctrl              irq_port
);

    csr_sel_e        sel;
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] current_val;
    logic [XLEN-1:0] new_val;
    logic            trap_event;
    logic            wr_en;

    always_comb begin
        case (address_i)
            ADDR_MVENDORID:  sel = SEL_MVENDORID;
            ADDR_MARCHID:    sel = SEL_MARCHID;
            ADDR_MIMPID:     sel = SEL_MIMPID;
            ADDR_MHARTID:    sel = SEL_MHARTID;
            ADDR_MCONFIGPTR: sel = SEL_MCONFIGPTR;
            ADDR_MSTATUS:    sel = SEL_MSTATUS;
            ADDR_MISA:       sel = SEL_MISA;
            ADDR_MIE:        sel = SEL_MIE;
            ADDR_MTVEC:      sel = SEL_MTVEC;
            ADDR_MSCRATCH:   sel = SEL_MSCRATCH;
            ADDR_MEPC:       sel = SEL_MEPC;
            ADDR_MCAUSE:     sel = SEL_MCAUSE;
            ADDR_MTVAL:      sel = SEL_MTVAL;
            ADDR_MIP:        sel = SEL_MIP;
            ADDR_MCYCLE:     sel = SEL_MCYCLE;
            ADDR_MCYCLEH:    sel = SEL_MCYCLEH;
            ADDR_MINSTRET:   sel = SEL_MINSTRET;
            ADDR_MINSTRETH:  sel = SEL_MINSTRETH;
            ADDR_CYCLE:      sel = SEL_CYCLE;
            ADDR_CYCLEH:     sel = SEL_CYCLEH;
            ADDR_INSTRET:    sel = SEL_INSTRET;
            ADDR_INSTRETH:   sel = SEL_INSTRETH;
            default:         sel = SEL_NONE;
        endcase
    end

    // Read-only and unknown selectors keep a zero mask
    always_comb begin
        case (sel)
            SEL_MSTATUS:           mask = MASK_MSTATUS;
            SEL_MIE:               mask = MASK_MIE;
            SEL_MTVEC, SEL_MEPC:   mask = MASK_ALIGNED;
            SEL_MSCRATCH, SEL_MCAUSE, SEL_MTVAL,
            SEL_MCYCLE, SEL_MCYCLEH,
            SEL_MINSTRET, SEL_MINSTRETH:
                                   mask = MASK_FULL;
            default:               mask = '0;
        endcase
    end

    assign current_val = trap_port.rd_data | cnt_port.rd_data | irq_port.rd_data;

    always_comb begin
        case (operation_i)
            SET:     new_val = (current_val | data_i) & mask;
            CLEAR:   new_val = current_val & ~data_i & mask;
            default: new_val = data_i & mask;
        endcase
    end

    // Trap events own the registers this cycle
    assign trap_event = raise_exception_i | machine_return_i | interrupt_ack_i;
    assign wr_en      = write_enable_i & ~killed_i & ~trap_event;

    // Identity registers read zero since no module owns them
    always_comb begin
        read_data_o = '0;
        if (read_enable_i && !killed_i) begin
            read_data_o = (sel == SEL_MISA) ? MISA_VALUE : current_val;
        end
    end

    //////////////////////////////
    // Broadcast to register modules
    //////////////////////////////
    assign trap_port.sel     = sel;
    assign trap_port.wr_en   = wr_en;
    assign trap_port.wr_data = new_val;
    assign cnt_port.sel      = sel;
    assign cnt_port.wr_en    = wr_en;
    assign cnt_port.wr_data  = new_val;
    assign irq_port.sel      = sel;
    assign irq_port.wr_en    = wr_en;
    assign irq_port.wr_data  = new_val;

endmodule

`default_nettype wire

/* source/csr_trap_regs.sv */
//////////////////////////////
// Machine trap registers
// Trap entry, return and CSR writes
//////////////////////////////
`default_nettype none

module csr_trap_regs
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            raise_exception_i,
    input  logic            machine_return_i,
    input  logic            interrupt_ack_i,
    input  logic            jump_i,
    input  exc_code_e       exception_code_i,
    input  irq_code_e       irq_code_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instruction_i,
    input  logic [XLEN-1:0] jump_target_i,
    csr_port_if.regs        port,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mie_o,
    output logic            global_ie_o,
    output priv_e           privilege_o
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    priv_e           privilege;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus   <= '0;
            mie       <= '0;
            mtvec     <= '0;
            mscratch  <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mtval     <= '0;
            privilege <= PRIV_MACHINE;
        end else if (machine_return_i) begin
            mstatus[MSTATUS_MIE] <= mstatus[MSTATUS_MPIE];
            privilege            <= priv_e'(mstatus[MSTATUS_MPP_LO +: 2]);
        end else if (raise_exception_i || interrupt_ack_i) begin
            // Common trap entry
            mstatus[MSTATUS_MPP_LO +: 2] <= privilege;
            mstatus[MSTATUS_MPIE]        <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]         <= 1'b0;
            privilege                    <= PRIV_MACHINE;
            if (raise_exception_i) begin
                mcause <= {1'b0, {(XLEN-6){1'b0}}, exception_code_i};
                mepc   <= (exception_code_i inside {ECALL_FROM_MMODE, BREAKPOINT})
                          ? pc_i
                          : pc_i + XLEN'(4);
                mtval  <= (exception_code_i == ILLEGAL_INSTRUCTION) ? instruction_i : pc_i;
            end else begin
                mcause <= {1'b1, {(XLEN-6){1'b0}}, irq_code_i};
                mepc   <= jump_i ? jump_target_i : pc_i;   // Resume at branch target
            end
        end else if (port.wr_en) begin
            case (port.sel)
                SEL_MSTATUS:  mstatus  <= port.wr_data;
                SEL_MIE:      mie      <= port.wr_data;
                SEL_MTVEC:    mtvec    <= port.wr_data;
                SEL_MSCRATCH: mscratch <= port.wr_data;
                SEL_MEPC:     mepc     <= port.wr_data;
                SEL_MCAUSE:   mcause   <= port.wr_data;
                SEL_MTVAL:    mtval    <= port.wr_data;
                default:      ;
            endcase
        end
    end

    always_comb begin
        case (port.sel)
            SEL_MSTATUS:  port.rd_data = mstatus;
            SEL_MIE:      port.rd_data = mie;
            SEL_MTVEC:    port.rd_data = mtvec;
            SEL_MSCRATCH: port.rd_data = mscratch;
            SEL_MEPC:     port.rd_data = mepc;
            SEL_MCAUSE:   port.rd_data = mcause;
            SEL_MTVAL:    port.rd_data = mtval;
            default:      port.rd_data = '0;
        endcase
    end

    assign mepc_o      = mepc;
    assign mtvec_o     = mtvec;
    assign mie_o       = mie;
    assign global_ie_o = mstatus[MSTATUS_MIE];
    assign privilege_o = privilege;

endmodule

`default_nettype wire

/* source/csr_counters.sv */
//////////////////////////////
// Cycle and retired-instruction counters
//////////////////////////////
`default_nettype none

module csr_counters
    import csr_addr_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     killed_i,
    csr_port_if.regs port
);

    logic [2*XLEN-1:0] mcycle;
    logic [2*XLEN-1:0] minstret;

    // A half-word write overrides the increment of that half
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            if (!killed_i) begin
                minstret <= minstret + 1'b1;
            end
            if (port.wr_en) begin
                case (port.sel)
                    SEL_MCYCLE:    mcycle[XLEN-1:0]        <= port.wr_data;
                    SEL_MCYCLEH:   mcycle[2*XLEN-1:XLEN]   <= port.wr_data;
                    SEL_MINSTRET:  minstret[XLEN-1:0]      <= port.wr_data;
                    SEL_MINSTRETH: minstret[2*XLEN-1:XLEN] <= port.wr_data;
                    default:       ;
                endcase
            end
        end
    end

    // User aliases are read-only views
    always_comb begin
        case (port.sel)
            SEL_MCYCLE, SEL_CYCLE:       port.rd_data = mcycle[XLEN-1:0];
            SEL_MCYCLEH, SEL_CYCLEH:     port.rd_data = mcycle[2*XLEN-1:XLEN];
            SEL_MINSTRET, SEL_INSTRET:   port.rd_data = minstret[XLEN-1:0];
            SEL_MINSTRETH, SEL_INSTRETH: port.rd_data = minstret[2*XLEN-1:XLEN];
            default:                     port.rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/csr_irq_unit.sv */
//////////////////////////////
// Interrupt unit
// Samples lines into mip, raises pending
//////////////////////////////
`default_nettype none

module csr_irq_unit
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] irq_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic            global_ie_i,
    input  logic            interrupt_ack_i,
    csr_port_if.regs        port,
    output logic            interrupt_pending_o,
    output irq_code_e       irq_code_o
);

    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] active;

    assign active = mie_i & mip;

    always_ff @(posedge clk) begin
        if (reset) begin
            mip                 <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip                 <= irq_i;
            interrupt_pending_o <= global_ie_i && (active != '0) && !interrupt_ack_i;
        end
    end

    // External first, then software, then timer
    always_ff @(posedge clk) begin
        if (active[M_EXT_INT]) begin
            irq_code_o <= M_EXT_INT;
        end else if (active[M_SW_INT]) begin
            irq_code_o <= M_SW_INT;
        end else if (active[M_TIM_INT]) begin
            irq_code_o <= M_TIM_INT;
        end
    end

    assign port.rd_data = (port.sel == SEL_MIP) ? mip : '0;   // Writes to mip are dropped

endmodule

`default_nettype wire

/* source/csr_bank_top.sv */
//////////////////////////////
// Machine-mode CSR bank
// Control and register modules behind plain ports
//////////////////////////////
`default_nettype none

module csr_bank_top
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read_enable_i,
    input  logic                  write_enable_i,
    input  logic                  killed_i,
    input  logic                  raise_exception_i,
    input  logic                  machine_return_i,
    input  logic                  interrupt_ack_i,
    input  logic                  jump_i,
    input  csr_op_e               operation_i,
    input  logic [CSR_ADDR_W-1:0] address_i,
    input  logic [XLEN-1:0]       data_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       instruction_i,
    input  logic [XLEN-1:0]       jump_target_i,
    input  exc_code_e             exception_code_i,
    input  logic [XLEN-1:0]       irq_i,
    output logic [XLEN-1:0]       read_data_o,
    output logic [XLEN-1:0]       mepc_o,
    output logic [XLEN-1:0]       mtvec_o,
    output logic                  interrupt_pending_o,
    output priv_e                 privilege_o
);

    logic [XLEN-1:0] mie;
    logic            global_ie;
    irq_code_e       irq_code;

    csr_port_if trap_if ();
    csr_port_if cnt_if ();
    csr_port_if irq_if ();

    csr_access_ctrl u_ctrl (
        .read_enable_i     (read_enable_i),
        .write_enable_i    (write_enable_i),
        .killed_i          (killed_i),
        .raise_exception_i (raise_exception_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .operation_i       (operation_i),
        .address_i         (address_i),
        .data_i            (data_i),
        .read_data_o       (read_data_o),
        .trap_port         (trap_if.ctrl),
        .cnt_port          (cnt_if.ctrl),
        .irq_port          (irq_if.ctrl)
    );

    csr_trap_regs u_trap (
        .clk               (clk),
        .reset             (reset),
        .raise_exception_i (raise_exception_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .jump_i            (jump_i),
        .exception_code_i  (exception_code_i),
        .irq_code_i        (irq_code),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .jump_target_i     (jump_target_i),
        .port              (trap_if.regs),
        .mepc_o            (mepc_o),
        .mtvec_o           (mtvec_o),
        .mie_o             (mie),
        .global_ie_o       (global_ie),
        .privilege_o       (privilege_o)
    );

    csr_counters u_cnt (
        .clk      (clk),
        .reset    (reset),
        .killed_i (killed_i),
        .port     (cnt_if.regs)
    );

    csr_irq_unit u_irq (
        .clk                 (clk),
        .reset               (reset),
        .irq_i               (irq_i),
        .mie_i               (mie),
        .global_ie_i         (global_ie),
        .interrupt_ack_i     (interrupt_ack_i),
        .port                (irq_if.regs),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_code_o          (irq_code)
    );

endmodule

`default_nettype wire

/* verification/csr_bank_tasks.svh */
//////////////////////////////
// Testbench tasks
// Bus drive, value checks and directed tests
//////////////////////////////

task automatic drive_idle();
    read_enable_i     = 1'b0;
    write_enable_i    = 1'b0;
    killed_i          = 1'b0;
    raise_exception_i = 1'b0;
    machine_return_i  = 1'b0;
    interrupt_ack_i   = 1'b0;
    jump_i            = 1'b0;
    operation_i       = WRITE;
    address_i         = '0;
    data_i            = '0;
    pc_i              = '0;
    instruction_i     = '0;
    jump_target_i     = '0;
    exception_code_i  = ILLEGAL_INSTRUCTION;
    irq_i             = '0;
endtask

task automatic compare(input string test_name, input logic [XLEN-1:0] expected,
                       input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
        $display("ERROR %s: expected %08h, actual %08h", test_name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "Value mismatch in %s", test_name);
    end
endtask

// Request held for one cycle so the write lands on the rising edge in between
task automatic write_csr(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
                         input logic [XLEN-1:0] data);
    write_enable_i = 1'b1;
    operation_i    = op;
    address_i      = addr;
    data_i         = data;
    @(negedge clk);
    write_enable_i = 1'b0;
endtask

task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
    read_enable_i = 1'b1;
    address_i     = addr;
    #2;                           // Combinational read settles mid low phase
    data = read_data_o;
    @(negedge clk);
    read_enable_i = 1'b0;
endtask

task automatic expect_csr(input string test_name, input logic [CSR_ADDR_W-1:0] addr,
                          input logic [XLEN-1:0] expected);
    logic [XLEN-1:0] value;
    read_csr(addr, value);
    compare(test_name, expected, value);
endtask

task automatic pulse_exception(input exc_code_e code, input logic [XLEN-1:0] pc,
                               input logic [XLEN-1:0] instr);
    raise_exception_i = 1'b1;
    exception_code_i  = code;
    pc_i              = pc;
    instruction_i     = instr;
    @(negedge clk);
    raise_exception_i = 1'b0;
endtask

task automatic pulse_return();
    machine_return_i = 1'b1;
    @(negedge clk);
    machine_return_i = 1'b0;
endtask

task automatic wait_pending(input logic level, input int max_cycles, input string what);
    int cycles;
    cycles = 0;
    while (interrupt_pending_o !== level && cycles < max_cycles) begin
        @(negedge clk);
        cycles++;
    end
    if (interrupt_pending_o !== level) begin
        $display("Interrupt pending did not %s within %0d cycles", what, max_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "Pending timeout");
    end
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic reset_values();
    expect_csr("reset_values", ADDR_MISA, 32'h4000_0100);
    expect_csr("reset_values", ADDR_MSTATUS, 32'h0);
    expect_csr("reset_values", ADDR_MIE, 32'h0);
    expect_csr("reset_values", ADDR_MSCRATCH, 32'h0);
    expect_csr("reset_values", ADDR_MVENDORID, 32'h0);
    expect_csr("reset_values", ADDR_MARCHID, 32'h0);
    expect_csr("reset_values", ADDR_MIMPID, 32'h0);
    expect_csr("reset_values", ADDR_MHARTID, 32'h0);
    expect_csr("reset_values", ADDR_MCONFIGPTR, 32'h0);
    compare("reset_values", 32'(PRIV_MACHINE), 32'(privilege_o));
    compare("reset_values", 32'h0, 32'(interrupt_pending_o));
endtask

task automatic write_set_clear();
    logic [XLEN-1:0] value;
    logic [XLEN-1:0] bits;
    logic [XLEN-1:0] data;
    value = $urandom();
    write_csr(WRITE, ADDR_MSCRATCH, value);
    expect_csr("write_set_clear", ADDR_MSCRATCH, value);
    data = $urandom();
    write_csr(WRITE, ADDR_MIE, data);
    expect_csr("write_set_clear", ADDR_MIE, data & MASK_MIE);
    data = $urandom();
    write_csr(WRITE, ADDR_MTVEC, data);
    expect_csr("write_set_clear", ADDR_MTVEC, data & MASK_ALIGNED);
    compare("write_set_clear", data & MASK_ALIGNED, mtvec_o);

    bits = $urandom();
    write_csr(SET, ADDR_MSCRATCH, bits);
    value = value | bits;
    expect_csr("write_set_clear", ADDR_MSCRATCH, value);
    bits = $urandom();
    write_csr(CLEAR, ADDR_MSCRATCH, bits);
    value = value & ~bits;
    expect_csr("write_set_clear", ADDR_MSCRATCH, value);

    killed_i = 1'b1;              // Killed write must not land
    write_csr(WRITE, ADDR_MSCRATCH, ~value);
    killed_i = 1'b0;
    expect_csr("write_set_clear", ADDR_MSCRATCH, value);

    killed_i = 1'b1;
    read_csr(ADDR_MSCRATCH, data);
    killed_i = 1'b0;
    compare("write_set_clear", 32'h0, data);
    address_i = ADDR_MSCRATCH;    // Read enable stays low
    #2;
    compare("write_set_clear", 32'h0, read_data_o);
    @(negedge clk);
endtask

task automatic counter_behavior();
    logic [XLEN-1:0] start;
    start = $urandom();
    write_csr(WRITE, ADDR_MCYCLE, start);
    expect_csr("counter_behavior", ADDR_MCYCLE, start);
    expect_csr("counter_behavior", ADDR_MCYCLE, start + 32'd1);
    expect_csr("counter_behavior", ADDR_MCYCLE, start + 32'd2);
    expect_csr("counter_behavior", ADDR_CYCLE, start + 32'd3);   // User alias of mcycle

    start = $urandom();
    write_csr(WRITE, ADDR_MINSTRET, start);
    killed_i = 1'b1;
    repeat (3) @(negedge clk);
    killed_i = 1'b0;
    expect_csr("counter_behavior", ADDR_MINSTRET, start);
    expect_csr("counter_behavior", ADDR_INSTRET, start + 32'd1);
endtask

task automatic exception_entry();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] keep;
    logic [XLEN-1:0] status;
    write_csr(WRITE, ADDR_MSTATUS, 32'h0);
    write_csr(SET, ADDR_MSTATUS, 32'h1 << MSTATUS_MIE);
    read_csr(ADDR_MSCRATCH, keep);
    pc    = $urandom() & MASK_ALIGNED;
    instr = $urandom();

    // Illegal instruction with a competing write
    write_enable_i = 1'b1;
    operation_i    = WRITE;
    address_i      = ADDR_MSCRATCH;
    data_i         = ~keep;
    pulse_exception(ILLEGAL_INSTRUCTION, pc, instr);
    write_enable_i = 1'b0;
    expect_csr("exception_entry", ADDR_MCAUSE, 32'd2);
    expect_csr("exception_entry", ADDR_MEPC, pc + 32'd4);
    expect_csr("exception_entry", ADDR_MTVAL, instr);
    expect_csr("exception_entry", ADDR_MSCRATCH, keep);
    status = 32'h0;
    status[MSTATUS_MPIE] = 1'b1;
    status[MSTATUS_MPP_LO +: 2] = PRIV_MACHINE;
    expect_csr("exception_entry", ADDR_MSTATUS, status);

    pulse_return();
    status[MSTATUS_MIE] = 1'b1;
    expect_csr("exception_entry", ADDR_MSTATUS, status);
    compare("exception_entry", 32'(PRIV_MACHINE), 32'(privilege_o));

    pc = $urandom() & MASK_ALIGNED;
    pulse_exception(ECALL_FROM_MMODE, pc, instr);
    compare("exception_entry", pc, mepc_o);
    status[MSTATUS_MIE] = 1'b0;   // MPIE picks up the set MIE
    expect_csr("exception_entry", ADDR_MSTATUS, status);
    pulse_return();
    status[MSTATUS_MIE] = 1'b1;
    expect_csr("exception_entry", ADDR_MSTATUS, status);
endtask

task automatic interrupt_entry();
    logic [XLEN-1:0] lines;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] status;
    lines = (32'h1 << M_EXT_INT) | (32'h1 << M_TIM_INT);
    write_csr(WRITE, ADDR_MIE, lines);
    write_csr(SET, ADDR_MSTATUS, 32'h1 << MSTATUS_MIE);
    irq_i = lines;
    wait_pending(1'b1, 4, "rise");

    target          = $urandom() & MASK_ALIGNED;
    pc_i            = ~target;
    jump_target_i   = target;
    jump_i          = 1'b1;
    interrupt_ack_i = 1'b1;
    @(negedge clk);
    interrupt_ack_i = 1'b0;
    jump_i          = 1'b0;
    wait_pending(1'b0, 2, "fall");

    compare("interrupt_entry", target, mepc_o);
    expect_csr("interrupt_entry", ADDR_MCAUSE, 32'h8000_0000 | 32'd11);
    read_csr(ADDR_MSTATUS, status);
    compare("interrupt_entry", 32'h0, 32'(status[MSTATUS_MIE]));
    irq_i = '0;
    @(negedge clk);
endtask

/* verification/csr_bank_tb.sv */
//////////////////////////////
// CSR bank testbench
// Directed tests on the machine-mode CSR bank
//////////////////////////////
`default_nettype none

module csr_bank_tb
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS   = 5;
    localparam int CYCLES_EACH = 200;     // Budget per directed test

    logic                  clk;
    logic                  reset;
    logic                  read_enable_i;
    logic                  write_enable_i;
    logic                  killed_i;
    logic                  raise_exception_i;
    logic                  machine_return_i;
    logic                  interrupt_ack_i;
    logic                  jump_i;
    csr_op_e               operation_i;
    logic [CSR_ADDR_W-1:0] address_i;
    logic [XLEN-1:0]       data_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       instruction_i;
    logic [XLEN-1:0]       jump_target_i;
    exc_code_e             exception_code_i;
    logic [XLEN-1:0]       irq_i;
    logic [XLEN-1:0]       read_data_o;
    logic [XLEN-1:0]       mepc_o;
    logic [XLEN-1:0]       mtvec_o;
    logic                  interrupt_pending_o;
    priv_e                 privilege_o;

    csr_bank_top uut (.*);

    `include "csr_bank_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Watchdog
    //////////////////////////////
    initial begin
        repeat (CYCLES_EACH * NUM_TESTS) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 CYCLES_EACH * NUM_TESTS);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        void'($urandom(12));
        reset = 1'b1;
        drive_idle();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;             // Tasks start on a falling edge

        reset_values();
        write_set_clear();
        counter_behavior();
        exception_entry();
        interrupt_entry();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verification
source/csr_addr_pkg.sv
source/csr_trap_pkg.sv
source/csr_port_if.sv
source/csr_access_ctrl.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_irq_unit.sv
source/csr_bank_top.sv
verification/csr_bank_tb.sv

/* Makefile */
# Verilator flow for the CSR bank testbench

VERILATOR ?= verilator
TOP       ?= csr_bank_tb
FILELIST  ?= tb.f
BUILD_DIR ?= build
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
